//--- execPkg.sv
`default_nettype none

package execPkg;

    // Data path widths
    localparam int dataWidth    = 32;
    localparam int immWidth     = 16;
    localparam int regAddrWidth = 4;

    // NZCV flag word
    localparam int flagWidth = 4;
    localparam int flagN     = 3;
    localparam int flagZ     = 2;
    localparam int flagC     = 1;
    localparam int flagV     = 0;

    // First level classes, top two instruction bits
    localparam logic [1:0] classImm    = 2'b00;
    localparam logic [1:0] classReg    = 2'b01;
    localparam logic [1:0] classMem    = 2'b10;
    localparam logic [1:0] classBranch = 2'b11;

    // Second level ALU codes, bit 3 set means flag update
    localparam logic [3:0] codeAdd  = 4'b0001;
    localparam logic [3:0] codeSub  = 4'b0010;
    localparam logic [3:0] codeAnd  = 4'b0011;
    localparam logic [3:0] codeOr   = 4'b0100;
    localparam logic [3:0] codeXor  = 4'b0101;
    localparam logic [3:0] codeNot  = 4'b0110;
    localparam logic [3:0] codeAdds = 4'b1001;
    localparam logic [3:0] codeSubs = 4'b1010;
    localparam logic [3:0] codeAnds = 4'b1011;
    localparam logic [3:0] codeOrs  = 4'b1100;
    localparam logic [3:0] codeXors = 4'b1101;
    localparam logic [3:0] codeSavf = 4'b1110;

    // Move family, on aluFunctions with specialEncoding low
    localparam logic [2:0] codeMov  = 3'b000;
    localparam logic [2:0] codeMovt = 3'b001;
    localparam logic [2:0] codeClr  = 3'b010;
    localparam logic [2:0] codeSet  = 3'b011;
    localparam logic [2:0] codeLsl  = 3'b100;
    localparam logic [2:0] codeLsr  = 3'b101;
    localparam logic [2:0] codeMovf = 3'b110;

    typedef enum logic [4:0] {
        opNop, opMov, opMovt, opClr, opSet, opLsl, opLsr, opMovf, opSavf,
        opAdd, opSub, opAnd, opOr, opXor, opNot,
        opLoad, opStore, opBranch
    } execOp;

    typedef enum logic [3:0] {
        condEq = 4'd0, condNe = 4'd1, condHs = 4'd2, condLo = 4'd3,
        condMi = 4'd4, condPl = 4'd5, condVs = 4'd6, condVc = 4'd7,
        condHi = 4'd8, condLs = 4'd9, condGe = 4'd10, condLt = 4'd11,
        condGt = 4'd12, condLe = 4'd13
    } condCode;

endpackage

`default_nettype wire

//--- instrDecode.sv
`timescale 1ns/1ns
`default_nettype none

module instrDecode #(
    parameter int regAddrWidth = execPkg::regAddrWidth
) (
    input  wire logic [1:0]              firstLevelDecode,
    input  wire logic                    specialEncoding,
    input  wire logic [3:0]              secondLevelDecode,
    input  wire logic [2:0]              aluFunctions,
    input  wire logic [regAddrWidth-1:0] destReg,
    input  wire logic [regAddrWidth-1:0] sourceFirstReg,
    input  wire logic [regAddrWidth-1:0] sourceSecReg,
    output execPkg::execOp               op,
    output logic                         setFlags,
    output logic                         useImm,
    output logic                         writeToReg,
    output logic                         memoryRead,
    output logic                         memoryWrite,
    output logic [regAddrWidth-1:0]      readRegDest,
    output logic [regAddrWidth-1:0]      readRegFirst,
    output logic [regAddrWidth-1:0]      readRegSec
);
    import execPkg::*;

    execOp aluOp;        // Second level code, before the class check
    logic  aluSetsFlags;

    always_comb begin
        case (secondLevelDecode)
            codeAdd, codeAdds: aluOp = opAdd;
            codeSub, codeSubs: aluOp = opSub;
            codeAnd, codeAnds: aluOp = opAnd;
            codeOr, codeOrs:   aluOp = opOr;
            codeXor, codeXors: aluOp = opXor;
            codeNot:           aluOp = opNot;
            codeSavf:          aluOp = opSavf;
            default:           aluOp = opNop;  // Multiply and spare codes
        endcase
    end

    // S variants only, SAVF shares bit 3 but loads flags itself
    assign aluSetsFlags = secondLevelDecode[3] && (aluOp != opSavf) && (aluOp != opNop);

    always_comb begin
        op           = opNop;
        setFlags     = 1'b0;
        useImm       = 1'b0;
        readRegDest  = '0;
        readRegFirst = '0;
        readRegSec   = '0;
        case (firstLevelDecode)
            classImm: begin
                if (!specialEncoding) begin
                    readRegDest = destReg;  // MOVT and MOVF merge the old value
                    case (aluFunctions)
                        codeMov:  op = opMov;
                        codeMovt: op = opMovt;
                        codeClr:  op = opClr;
                        codeSet:  op = opSet;
                        codeLsl: begin
                            op           = opLsl;
                            readRegFirst = sourceFirstReg;
                        end
                        codeLsr: begin
                            op           = opLsr;
                            readRegFirst = sourceFirstReg;
                        end
                        codeMovf: op = opMovf;
                        default:  readRegDest = '0;
                    endcase
                end else if (aluOp == opSavf) begin
                    op           = opSavf;
                    readRegFirst = sourceFirstReg;
                    readRegDest  = sourceFirstReg;  // Nibble written back to the source
                end else if (aluOp != opNop && aluOp != opNot) begin
                    op           = aluOp;
                    setFlags     = aluSetsFlags;
                    useImm       = 1'b1;
                    readRegDest  = destReg;
                    readRegFirst = sourceFirstReg;
                end
            end
            classReg: begin
                if (aluOp != opNop && aluOp != opSavf) begin
                    op           = aluOp;
                    setFlags     = aluSetsFlags;
                    readRegDest  = destReg;
                    readRegFirst = sourceFirstReg;
                    if (aluOp != opNot)
                        readRegSec = sourceSecReg;
                end
            end
            classMem: begin
                op           = aluFunctions[0] ? opStore : opLoad;
                readRegFirst = sourceFirstReg;  // Base
                readRegDest  = destReg;         // Store data or load target
            end
            classBranch: op = opBranch;
        endcase
    end

    assign writeToReg  = (op != opNop) && (op != opStore) && (op != opBranch);
    assign memoryRead  = (op == opLoad);
    assign memoryWrite = (op == opStore);

endmodule

`default_nettype wire

//--- aluUnit.sv
`timescale 1ns/1ns
`default_nettype none

module aluUnit #(
    parameter int dataWidth = execPkg::dataWidth,
    parameter int immWidth  = execPkg::immWidth
) (
    input  wire execPkg::execOp                 op,
    input  wire logic                           setFlags,
    input  wire logic                           useImm,
    input  wire logic [immWidth-1:0]            imm,
    input  wire logic [dataWidth-1:0]           srcFirst,
    input  wire logic [dataWidth-1:0]           srcSec,
    input  wire logic [dataWidth-1:0]           srcDest,
    input  wire logic [execPkg::flagWidth-1:0]  flags,
    output logic [dataWidth-1:0]                aluResult,
    output logic [execPkg::flagWidth-1:0]       flagsNext,
    output logic [execPkg::flagWidth-1:0]       flagsWriteMask
);
    import execPkg::*;

    localparam int msb = dataWidth - 1;

    logic [dataWidth-1:0] immSext;
    logic [dataWidth-1:0] immZext;
    logic [dataWidth-1:0] operandB;
    logic [dataWidth:0]   sum;
    logic [dataWidth:0]   diff;
    logic                 carry;
    logic                 overflow;
    logic                 isArith;
    logic                 isLogic;

    assign immSext  = {{(dataWidth-immWidth){imm[immWidth-1]}}, imm};
    assign immZext  = {{(dataWidth-immWidth){1'b0}}, imm};
    assign operandB = useImm ? immSext : srcSec;

    // One extra bit holds the carry out
    assign sum  = {1'b0, srcFirst} + {1'b0, operandB};
    assign diff = {1'b0, srcFirst} - {1'b0, operandB};

    always_comb begin
        case (op)
            opMov:  aluResult = immZext;
            opMovt: aluResult = {imm, srcDest[dataWidth-immWidth-1:0]};
            opClr:  aluResult = '0;
            opSet:  aluResult = '1;
            opLsl:  aluResult = srcFirst << imm;  // Zero once imm reaches the width
            opLsr:  aluResult = srcFirst >> imm;
            opMovf: aluResult = {{(dataWidth-8-flagWidth){1'b0}}, srcDest[msb -: 8], flags};
            opSavf: aluResult = {{(dataWidth-flagWidth){1'b0}}, srcFirst[flagWidth-1:0]};
            opAdd:  aluResult = sum[msb:0];
            opSub:  aluResult = diff[msb:0];
            opAnd:  aluResult = srcFirst & operandB;
            opOr:   aluResult = srcFirst | operandB;
            opXor:  aluResult = srcFirst ^ operandB;
            opNot:  aluResult = ~srcFirst;
            default: aluResult = '0;
        endcase
    end

    always_comb begin
        if (op == opSub) begin
            carry    = ~diff[dataWidth];  // Set when no borrow
            overflow = (srcFirst[msb] ^ operandB[msb]) & (srcFirst[msb] ^ aluResult[msb]);
        end else begin
            carry    = sum[dataWidth];
            overflow = ~(srcFirst[msb] ^ operandB[msb]) & (srcFirst[msb] ^ aluResult[msb]);
        end
    end

    assign isArith = (op == opAdd) || (op == opSub);
    assign isLogic = (op == opAnd) || (op == opOr) || (op == opXor);

    // Mask picks which NZCV bits the register takes
    always_comb begin
        flagsNext      = '0;
        flagsWriteMask = '0;
        if (op == opSavf) begin
            flagsNext      = srcFirst[flagWidth-1:0];
            flagsWriteMask = '1;
        end else begin
            flagsNext[flagN] = aluResult[msb];
            flagsNext[flagZ] = (aluResult == '0);
            flagsNext[flagC] = carry;
            flagsNext[flagV] = overflow;
            if (setFlags && isArith) begin
                flagsWriteMask = '1;
            end else if (setFlags && isLogic) begin
                // C and V kept for logic ops
                flagsWriteMask[flagN] = 1'b1;
                flagsWriteMask[flagZ] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- memStage.sv
`timescale 1ns/1ns
`default_nettype none

module memStage #(
    parameter int dataWidth = execPkg::dataWidth,
    parameter int immWidth  = execPkg::immWidth
) (
    input  wire execPkg::execOp       op,
    input  wire logic [immWidth-1:0]  imm,
    input  wire logic [dataWidth-1:0] base,
    input  wire logic [dataWidth-1:0] storeData,
    input  wire logic [dataWidth-1:0] aluResult,
    input  wire logic [dataWidth-1:0] memoryDataIn,
    output logic [dataWidth-1:0]      memoryAddressOut,
    output logic [dataWidth-1:0]      memoryDataOut,
    output logic [dataWidth-1:0]      writeData
);
    import execPkg::*;

    logic [dataWidth-1:0] offset;
    logic                 isLoad;
    logic                 isStore;

    assign offset  = {{(dataWidth-immWidth){imm[immWidth-1]}}, imm};
    assign isLoad  = (op == opLoad);
    assign isStore = (op == opStore);

    // Bus stays at zero outside memory ops
    assign memoryAddressOut = (isLoad || isStore) ? base + offset : '0;
    assign memoryDataOut    = isStore ? storeData : '0;

    // Load data bypasses the ALU result
    assign writeData = isLoad ? memoryDataIn : aluResult;

endmodule

`default_nettype wire

//--- condFlags.sv
`timescale 1ns/1ns
`default_nettype none

module condFlags (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire execPkg::execOp                op,
    input  wire logic [3:0]                    branchInstruction,
    input  wire logic [execPkg::flagWidth-1:0] flagsNext,
    input  wire logic [execPkg::flagWidth-1:0] flagsWriteMask,
    output logic [execPkg::flagWidth-1:0]      flags,
    output logic                               exeOverride
);
    import execPkg::*;

    condCode cond;
    logic    n;
    logic    z;
    logic    c;
    logic    v;
    logic    condTrue;

    // NZCV register, masked merge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags <= '0;
        end else begin
            flags <= (flagsNext & flagsWriteMask) | (flags & ~flagsWriteMask);
        end
    end

    assign n = flags[flagN];
    assign z = flags[flagZ];
    assign c = flags[flagC];
    assign v = flags[flagV];

    assign cond = condCode'(branchInstruction);

    always_comb begin
        case (cond)
            condEq: condTrue = z;
            condNe: condTrue = ~z;
            condHs: condTrue = c;
            condLo: condTrue = ~c;
            condMi: condTrue = n;
            condPl: condTrue = ~n;
            condVs: condTrue = v;
            condVc: condTrue = ~v;
            condHi: condTrue = c & ~z;     // Unsigned higher
            condLs: condTrue = ~(c & ~z);
            condGe: condTrue = (n == v);   // Signed compare
            condLt: condTrue = (n != v);
            condGt: condTrue = ~z & (n == v);
            condLe: condTrue = ~(~z & (n == v));
            default: condTrue = 1'b0;      // Codes 14 and 15 never taken
        endcase
    end

    // Registered flags only, the current op cannot steer its own branch
    assign exeOverride = (op == opBranch) && condTrue;

endmodule

`default_nettype wire

//--- execTop.sv
`timescale 1ns/1ns
`default_nettype none

module execTop #(
    parameter int dataWidth    = execPkg::dataWidth,
    parameter int immWidth     = execPkg::immWidth,
    parameter int regAddrWidth = execPkg::regAddrWidth
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic [1:0]                    firstLevelDecode,
    input  wire logic                          specialEncoding,
    input  wire logic [3:0]                    secondLevelDecode,
    input  wire logic [2:0]                    aluFunctions,
    input  wire logic [3:0]                    branchInstruction,
    input  wire logic [immWidth-1:0]           imm,
    input  wire logic [regAddrWidth-1:0]       destReg,
    input  wire logic [regAddrWidth-1:0]       sourceFirstReg,
    input  wire logic [regAddrWidth-1:0]       sourceSecReg,
    input  wire logic [dataWidth-1:0]          readDataDest,
    input  wire logic [dataWidth-1:0]          readDataFirst,
    input  wire logic [dataWidth-1:0]          readDataSec,
    input  wire logic [dataWidth-1:0]          memoryDataIn,
    output wire logic [regAddrWidth-1:0]       readRegDest,
    output wire logic [regAddrWidth-1:0]       readRegFirst,
    output wire logic [regAddrWidth-1:0]       readRegSec,
    output wire logic [dataWidth-1:0]          writeData,
    output wire logic                          writeToReg,
    output wire logic                          exeOverride,
    output wire logic [execPkg::flagWidth-1:0] flagsOut,
    output wire logic [dataWidth-1:0]          memoryDataOut,
    output wire logic [dataWidth-1:0]          memoryAddressOut,
    output wire logic                          memoryWrite,
    output wire logic                          memoryRead
);
    import execPkg::*;

    wire execOp                 op;
    wire logic                  setFlags;
    wire logic                  useImm;
    wire logic [dataWidth-1:0]  aluResult;
    wire logic [flagWidth-1:0]  flagsNext;
    wire logic [flagWidth-1:0]  flagsWriteMask;
    wire logic [flagWidth-1:0]  flags;

    instrDecode #(.regAddrWidth(regAddrWidth)) i_decode (
        .firstLevelDecode, .specialEncoding, .secondLevelDecode, .aluFunctions,
        .destReg, .sourceFirstReg, .sourceSecReg,
        .op, .setFlags, .useImm, .writeToReg, .memoryRead, .memoryWrite,
        .readRegDest, .readRegFirst, .readRegSec
    );

    aluUnit #(.dataWidth(dataWidth), .immWidth(immWidth)) i_alu (
        .op, .setFlags, .useImm, .imm,
        .srcFirst (readDataFirst),
        .srcSec   (readDataSec),
        .srcDest  (readDataDest),
        .flags, .aluResult, .flagsNext, .flagsWriteMask
    );

    memStage #(.dataWidth(dataWidth), .immWidth(immWidth)) i_mem (
        .op, .imm,
        .base      (readDataFirst),
        .storeData (readDataDest),  // Store data comes from the dest field
        .aluResult, .memoryDataIn,
        .memoryAddressOut, .memoryDataOut, .writeData
    );

    condFlags i_flags (
        .clk, .rst, .op, .branchInstruction,
        .flagsNext, .flagsWriteMask, .flags, .exeOverride
    );

    assign flagsOut = flags;

endmodule

`default_nettype wire

//--- tbExecModel.svh
`ifndef TB_EXEC_MODEL_SVH
`define TB_EXEC_MODEL_SVH

// Expected ALU result for a second-level code, b already extended
function automatic logic [31:0] expectAlu(input logic [3:0] code, input logic [31:0] a,
                                          input logic [31:0] b);
    case (code & 4'b0111)
        4'd1: return a + b;
        4'd2: return a - b;
        4'd3: return a & b;
        4'd4: return a | b;
        4'd5: return a ^ b;
        4'd6: return ~a;
        default: return 32'h0;
    endcase
endfunction

// Next NZCV after an ALU code, old flags kept without the S bit
function automatic logic [3:0] expectFlags(input logic [3:0] code, input logic [31:0] a,
                                           input logic [31:0] b, input logic [3:0] old);
    logic [32:0] wide;
    logic [31:0] res;
    logic [3:0]  f;
    f = old;
    if (!code[3] || code == codeSavf)
        return old;
    res = expectAlu(code, a, b);
    f[flagN] = res[31];
    f[flagZ] = (res == 32'h0);
    if (code == codeAdds) begin
        wide = {1'b0, a} + {1'b0, b};
        f[flagC] = wide[32];
        f[flagV] = (a[31] == b[31]) && (res[31] != a[31]);
    end else if (code == codeSubs) begin
        f[flagC] = (a >= b);  // No borrow
        f[flagV] = (a[31] != b[31]) && (res[31] != a[31]);
    end
    return f;
endfunction

// Move and shift family
function automatic logic [31:0] expectMove(input logic [2:0] func, input logic [15:0] immVal,
                                           input logic [31:0] dest, input logic [31:0] first,
                                           input logic [3:0] f);
    case (func)
        3'd0: return {16'h0, immVal};
        3'd1: return {immVal, dest[15:0]};
        3'd2: return 32'h0;
        3'd3: return 32'hffff_ffff;
        3'd4: return (immVal >= 32) ? 32'h0 : first << immVal;
        3'd5: return (immVal >= 32) ? 32'h0 : first >> immVal;
        3'd6: return {20'h0, dest[31:24], f};
        default: return 32'h0;
    endcase
endfunction

function automatic logic expectTaken(input logic [3:0] cond, input logic [3:0] f);
    logic n, z, c, v;
    {n, z, c, v} = f;
    case (cond)
        4'd0: return z;
        4'd1: return !z;
        4'd2: return c;
        4'd3: return !c;
        4'd4: return n;
        4'd5: return !n;
        4'd6: return v;
        4'd7: return !v;
        4'd8: return c && !z;
        4'd9: return !(c && !z);
        4'd10: return n == v;
        4'd11: return n != v;
        4'd12: return !z && (n == v);
        4'd13: return z || (n != v);
        default: return 1'b0;
    endcase
endfunction

`endif

//--- tbExecTop.sv
`timescale 1ns/1ns
`default_nettype none

module tbExecTop;
    import execPkg::*;

    logic        clk, rst;
    logic [1:0]  firstLevelDecode;
    logic        specialEncoding;
    logic [3:0]  secondLevelDecode, branchInstruction;
    logic [2:0]  aluFunctions;
    logic [15:0] imm;
    logic [3:0]  destReg, sourceFirstReg, sourceSecReg;
    logic [31:0] readDataDest, readDataFirst, readDataSec, memoryDataIn;
    wire  [3:0]  readRegDest, readRegFirst, readRegSec, flagsOut;
    wire  [31:0] writeData, memoryDataOut, memoryAddressOut;
    wire         writeToReg, exeOverride, memoryWrite, memoryRead;

    logic [31:0] seed = 32'h9400_f175;
    logic [3:0]  expFlags;
    logic [3:0]  expSec;
    logic [31:0] b, expData;
    logic [3:0]  code;

    `include "tbExecModel.svh"

    execTop i_execTop (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        seed ^= seed << 13;
        seed ^= seed >> 17;
        seed ^= seed << 5;
        return seed;
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic nextEdge();
        int ticks;
        ticks = 0;
        while (clk !== 1'b0 && ticks < 200) begin
            #1;
            ticks++;
        end
        while (clk !== 1'b1 && ticks < 200) begin
            #1;
            ticks++;
        end
        if (ticks >= 200) begin
            $display("no rising clock edge seen within 200 ns");
            $display("test failed");
            $fatal(1);
        end
    endtask

    // Checks flags from the last instruction, then drives the next one with random data
    task automatic driveInstr(input logic [1:0] cls, input logic spec, input logic [3:0] sec,
                              input logic [2:0] func, input logic [3:0] br);
        nextEdge();
        #5;
        assert (flagsOut === expFlags) else reportMismatch("flagsOut", flagsOut, expFlags);
        #5;
        {firstLevelDecode, specialEncoding, secondLevelDecode} = {cls, spec, sec};
        {aluFunctions, branchInstruction} = {func, br};
        {destReg, sourceFirstReg, sourceSecReg} = nextRand();
        readDataDest  = nextRand();
        readDataFirst = nextRand();
        readDataSec   = (nextRand() % 8 == 0) ? readDataFirst : nextRand();  // Hits Z now and then
        memoryDataIn  = nextRand();
        imm           = nextRand();
    endtask

    task automatic checkOutputs(input logic [31:0] data, input logic we, input logic rd,
                                input logic wr, input logic [31:0] addr, input logic [31:0] memOut,
                                input logic taken);
        #70;
        if (we)
            assert (writeData === data) else reportMismatch("writeData", writeData, data);
        assert (writeToReg === we) else reportMismatch("writeToReg", writeToReg, we);
        assert (memoryRead === rd) else reportMismatch("memoryRead", memoryRead, rd);
        assert (memoryWrite === wr) else reportMismatch("memoryWrite", memoryWrite, wr);
        assert (memoryAddressOut === addr)
            else reportMismatch("memoryAddressOut", memoryAddressOut, addr);
        assert (memoryDataOut === memOut)
            else reportMismatch("memoryDataOut", memoryDataOut, memOut);
        assert (exeOverride === taken) else reportMismatch("exeOverride", exeOverride, taken);
    endtask

    initial begin
        {firstLevelDecode, specialEncoding, secondLevelDecode, aluFunctions} = '0;
        {branchInstruction, imm, destReg, sourceFirstReg, sourceSecReg} = '0;
        {readDataDest, readDataFirst, readDataSec, memoryDataIn} = '0;
        rst = 1'b1;
        expFlags = 4'h0;
        repeat (8) nextEdge();
        #10 rst = 1'b0;

        driveInstr(classBranch, 0, 0, 0, condEq);
        checkOutputs(0, 0, 0, 0, 0, 0, 0);
        driveInstr(classBranch, 0, 0, 0, condNe);
        checkOutputs(0, 0, 0, 0, 0, 0, 1);

        // Register ALU ops first and immediate ALU ops without NOT after
        for (int i = 0; i < 120; i++) begin
            code = (nextRand() % 2) ? 4'd1 + nextRand() % 6 : 4'd9 + nextRand() % 5;
            if (i >= 60 && code == codeNot)
                code = codeXor;
            driveInstr(i < 60 ? classReg : classImm, i >= 60, code, 0, 0);
            b = (i < 60) ? readDataSec : {{16{imm[15]}}, imm};
            checkOutputs(expectAlu(code, readDataFirst, b), 1, 0, 0, 0, 0, 0);
            assert (readRegDest === destReg)
                else reportMismatch("readRegDest", readRegDest, destReg);
            assert (readRegFirst === sourceFirstReg)
                else reportMismatch("readRegFirst", readRegFirst, sourceFirstReg);
            expSec = (i < 60 && code != codeNot) ? sourceSecReg : 4'h0;  // Unused field reads zero
            assert (readRegSec === expSec) else reportMismatch("readRegSec", readRegSec, expSec);
            expFlags = expectFlags(code, readDataFirst, b, expFlags);
        end

        // Move family with shift amounts past the width now and then
        for (int i = 0; i < 60; i++) begin
            driveInstr(classImm, 0, 0, i % 7, 0);
            if (i % 3 == 0)
                imm = imm % 64;
            checkOutputs(expectMove(i % 7, imm, readDataDest, readDataFirst, expFlags),
                         1, 0, 0, 0, 0, 0);
        end

        // SAVF then every branch code on the loaded flags
        for (int i = 0; i < 8; i++) begin
            driveInstr(classImm, 1, codeSavf, 0, 0);
            checkOutputs({28'h0, readDataFirst[3:0]}, 1, 0, 0, 0, 0, 0);
            assert (readRegDest === sourceFirstReg)
                else reportMismatch("readRegDest", readRegDest, sourceFirstReg);
            expFlags = readDataFirst[3:0];
            for (int c = 0; c < 16; c++) begin
                driveInstr(classBranch, 0, 0, 0, c);
                checkOutputs(0, 0, 0, 0, 0, 0, expectTaken(c, expFlags));
            end
        end

        // Loads and stores in turn
        for (int i = 0; i < 20; i++) begin
            driveInstr(classMem, 0, 0, i % 2, 0);
            expData = readDataFirst + {{16{imm[15]}}, imm};
            if (i % 2)
                checkOutputs(0, 0, 0, 1, expData, readDataDest, 0);
            else
                checkOutputs(memoryDataIn, 1, 1, 0, expData, 0, 0);
        end

        // Multiply and spare encodings do nothing
        for (int i = 0; i < 16; i++) begin
            driveInstr(classReg, 0, (i % 2) ? 4'b0111 : 4'b1111, 0, 0);
            checkOutputs(0, 0, 0, 0, 0, 0, 0);
            driveInstr(classImm, i % 2, (i % 2) ? codeNot : 4'b0000, 3'b111, 0);
            checkOutputs(0, 0, 0, 0, 0, 0, 0);
        end

        driveInstr(classReg, 0, 0, 0, 0);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
execPkg.sv
instrDecode.sv
aluUnit.sv
memStage.sv
condFlags.sv
execTop.sv
tbExecTop.sv
